//--- apr_pkg.sv
package apr_pkg;

	localparam int WORD_BITS = 36;
	localparam int HALF_BITS = 18;

	// Bit 0 is the most significant bit
	typedef logic [0:WORD_BITS-1] word_t;
	typedef logic [0:HALF_BITS-1] half_t;

	// Address covers the right half of a word
	typedef logic [WORD_BITS-HALF_BITS:WORD_BITS-1] addr_t;

	typedef struct packed {
		half_t lt;	// Bits 0 to 17
		half_t rt;	// Bits 18 to 35
	} halves_t;

	// Whole word for bus moves, halves for the split clear and load
	typedef union packed {
		word_t   w;
		halves_t h;
	} word_u;

endpackage

//--- membus_pkg.sv
package membus_pkg;

	// Console timing chain
	localparam int KEY_T1_CYCLES   = 2;	// Key edge to kt1
	localparam int KEY_STEP_CYCLES = 4;	// kt1 to kt2, kt2 to kt3
	localparam int KEY_CNT_BITS    = $clog2(KEY_STEP_CYCLES);

	// Cycles without addr_ack before the cycle is dropped
	localparam int NXM_TIMEOUT_CYCLES = 32;
	localparam int NXM_CNT_BITS       = $clog2(NXM_TIMEOUT_CYCLES);

	typedef logic [KEY_CNT_BITS-1:0] key_cnt_t;
	typedef logic [NXM_CNT_BITS-1:0] nxm_cnt_t;

	// One-cycle console pulses
	typedef struct packed {
		logic ma_clr;
		logic ma_inc;
		logic ma_fm_mas;
		logic ar_clr;
		logic ar_fm_datasw;
		logic mb_fm_ar;
		logic rq;
		logic rq_wr;	// Qualifies rq, high for a write
	} key_pulses_t;

	// Processor to memory
	typedef struct packed {
		logic           rq_cyc;
		logic           rd_rq;
		logic           wr_rq;
		logic           wr_rs;
		logic [21:35]   ma;
		logic [18:21]   sel;
		apr_pkg::word_t mb_out;
	} membus_req_t;

	// Memory to processor
	typedef struct packed {
		logic           addr_ack;
		logic           rd_rs;
		apr_pkg::word_t mb_in;
	} membus_rsp_t;

endpackage

//--- console_keys.sv
module console_keys (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    key_ex,
	input  logic                    key_ex_nxt,
	input  logic                    key_dep,
	input  logic                    key_dep_nxt,
	input  logic                    cycle_done,
	output membus_pkg::key_pulses_t pulses
);

	logic key_any;
	logic key_any_q;
	logic key_edge;
	logic busy;
	logic sel_dep;	// Deposit or deposit next
	logic sel_nxt;	// One of the next keys
	logic kt0;
	logic timing;
	logic tick;
	logic kt1;
	logic kt2;
	logic kt3;
	logic [1:0] stage;
	membus_pkg::key_cnt_t cnt;

	assign key_any  = key_ex | key_ex_nxt | key_dep | key_dep_nxt;
	assign key_edge = key_any & ~key_any_q & ~busy;

	always_ff @(posedge clk) begin
		if (rst) begin
			key_any_q <= 1'b0;
			kt0       <= 1'b0;
			busy      <= 1'b0;
			sel_dep   <= 1'b0;
			sel_nxt   <= 1'b0;
		end else begin
			key_any_q <= key_any;
			kt0       <= key_edge;
			if (key_edge) begin
				busy    <= 1'b1;
				sel_dep <= key_dep | key_dep_nxt;
				sel_nxt <= key_ex_nxt | key_dep_nxt;
			end else if (cycle_done) begin
				busy <= 1'b0;
			end
		end
	end

	// kt1..kt3 from one down-counter, stage says which is next
	assign tick = timing & (cnt == '0);
	assign kt1  = tick & (stage == 2'd1);
	assign kt2  = tick & (stage == 2'd2);
	assign kt3  = tick & (stage == 2'd3);

	always_ff @(posedge clk) begin
		if (rst) begin
			timing <= 1'b0;
			stage  <= 2'd0;
			cnt    <= '0;
		end else if (kt0) begin
			timing <= 1'b1;
			stage  <= 2'd1;
			cnt    <= membus_pkg::key_cnt_t'(membus_pkg::KEY_T1_CYCLES - 2);
		end else if (tick) begin
			stage <= stage + 2'd1;
			cnt   <= membus_pkg::key_cnt_t'(membus_pkg::KEY_STEP_CYCLES - 1);
			if (kt3)
				timing <= 1'b0;	// Chain done, wait for cycle_done
		end else if (timing) begin
			cnt <= cnt - membus_pkg::key_cnt_t'(1);
		end
	end

	always_comb begin
		pulses.ma_clr       = kt1 & ~sel_nxt;
		pulses.ma_inc       = kt1 & sel_nxt;
		pulses.ar_clr       = kt1 & sel_dep;
		pulses.ma_fm_mas    = kt2 & ~sel_nxt;
		pulses.ar_fm_datasw = kt2 & sel_dep;
		pulses.mb_fm_ar     = kt3 & sel_dep;
		pulses.rq           = kt3;
		pulses.rq_wr        = kt3 & sel_dep;
	end

endmodule

//--- memory_address.sv
module memory_address (
	input  logic                    clk,
	input  logic                    rst,
	input  membus_pkg::key_pulses_t pulses,
	input  apr_pkg::addr_t          mas,
	input  logic                    sw_addr_stop,
	output apr_pkg::addr_t          ma,
	output logic                    addr_match
);

	always_ff @(posedge clk) begin
		if (rst) begin
			ma <= '0;
		end else if (pulses.ma_clr) begin
			ma <= '0;
		end else if (pulses.ma_inc) begin
			ma <= ma + apr_pkg::addr_t'(1);	// Wraps at the top
		end else if (pulses.ma_fm_mas) begin
			ma <= ma | mas;	// OR in, relies on the earlier clear
		end
	end

	// Address stop compare
	assign addr_match = sw_addr_stop & (ma == mas);

endmodule

//--- ar_mb_path.sv
module ar_mb_path (
	input  logic                    clk,
	input  logic                    rst,
	input  membus_pkg::key_pulses_t pulses,
	input  apr_pkg::word_t          datasw,
	input  logic                    mb_clr,
	input  logic                    mb_fm_bus,
	input  apr_pkg::word_t          bus_word,
	output apr_pkg::word_t          ar,
	output apr_pkg::word_t          mb
);

	apr_pkg::word_u ar_q;
	apr_pkg::word_u mb_q;
	apr_pkg::word_u ds;

	// Clear first, then OR in the source
	function automatic apr_pkg::half_t half_next(
		input apr_pkg::half_t cur,
		input logic           clr,
		input logic           load,
		input apr_pkg::half_t src
	);
		half_next = (clr ? '0 : cur) | (load ? src : '0);
	endfunction

	assign ds.w = datasw;

	always_ff @(posedge clk) begin
		if (rst) begin
			ar_q <= '0;
		end else begin
			ar_q.h.lt <= half_next(ar_q.h.lt, pulses.ar_clr, pulses.ar_fm_datasw, ds.h.lt);
			ar_q.h.rt <= half_next(ar_q.h.rt, pulses.ar_clr, pulses.ar_fm_datasw, ds.h.rt);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			mb_q <= '0;
		end else if (pulses.mb_fm_ar) begin
			mb_q.w <= ar_q.w;
		end else if (mb_fm_bus) begin
			mb_q.w <= mb_q.w | bus_word;	// Read strobe ORs into a cleared mb
		end else if (mb_clr) begin
			mb_q.h.lt <= '0;
			mb_q.h.rt <= '0;
		end
	end

	assign ar = ar_q.w;
	assign mb = mb_q.w;

endmodule

//--- membus_ctl.sv
module membus_ctl (
	input  logic                    clk,
	input  logic                    rst,
	input  membus_pkg::key_pulses_t pulses,
	input  apr_pkg::addr_t          ma,
	input  logic                    addr_match,
	input  apr_pkg::word_t          mb,
	input  logic                    key_mem_stop,
	input  logic                    key_mem_cont,
	input  membus_pkg::membus_rsp_t rsp,
	output membus_pkg::membus_req_t req,
	output logic                    mb_clr,
	output logic                    mb_fm_bus,
	output logic                    mc_stop,
	output logic                    cycle_done
);

	logic mc_rd;
	logic mc_wr;
	logic mc_rq;
	logic rs_pend;	// Response half still open
	logic rs_held;	// Response done, held by mc_stop
	logic wr_rs_q;
	logic cont_q;
	logic cont_edge;
	logic nxm_hit;
	logic ack_evt;
	logic rd_seen;
	logic rs_end;
	membus_pkg::nxm_cnt_t nxm_cnt;

	assign cont_edge = key_mem_cont & ~cont_q;

	// Timeout acts as the acknowledge of a missing memory
	assign nxm_hit = mc_rq & ~rsp.addr_ack &
		(int'(nxm_cnt) == membus_pkg::NXM_TIMEOUT_CYCLES - 1);
	assign ack_evt = mc_rq & (rsp.addr_ack | nxm_hit);
	assign rd_seen = mc_rd & rs_pend & rsp.rd_rs;
	assign rs_end  = rd_seen | (mc_rd & nxm_hit) | wr_rs_q;

	assign mb_clr    = pulses.rq & ~pulses.rq_wr;
	assign mb_fm_bus = rd_seen;

	always_ff @(posedge clk) begin
		if (rst | pulses.rq)
			nxm_cnt <= '0;
		else if (mc_rq & ~rsp.addr_ack)
			nxm_cnt <= nxm_cnt + membus_pkg::nxm_cnt_t'(1);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			mc_rd      <= 1'b0;
			mc_wr      <= 1'b0;
			mc_rq      <= 1'b0;
			mc_stop    <= 1'b0;
			rs_pend    <= 1'b0;
			rs_held    <= 1'b0;
			wr_rs_q    <= 1'b0;
			cont_q     <= 1'b0;
			cycle_done <= 1'b0;
		end else begin
			cont_q     <= key_mem_cont;
			wr_rs_q    <= ack_evt & mc_wr;	// Write restart after the ack
			cycle_done <= (rs_end & ~mc_stop) | (rs_held & cont_edge);
			if (pulses.rq) begin
				mc_rq   <= 1'b1;
				mc_rd   <= ~pulses.rq_wr;
				mc_wr   <= pulses.rq_wr;
				mc_stop <= addr_match | key_mem_stop;
				rs_pend <= 1'b1;
			end else begin
				if (ack_evt)
					mc_rq <= 1'b0;
				if (rs_end) begin
					rs_pend <= 1'b0;
					rs_held <= mc_stop;
				end
				if (rs_held & cont_edge) begin
					rs_held <= 1'b0;
					mc_stop <= 1'b0;
				end
				if (cycle_done) begin
					mc_rd <= 1'b0;
					mc_wr <= 1'b0;
				end
			end
		end
	end

	// No relocation, so the bus address is ma itself
	always_comb begin
		req.rq_cyc = mc_rq & (mc_rd | mc_wr);
		req.rd_rq  = mc_rd;
		req.wr_rq  = mc_wr;
		req.wr_rs  = wr_rs_q;
		req.ma     = ma[21:35];
		req.sel    = ma[18:21];
		req.mb_out = wr_rs_q ? mb : '0;
	end

endmodule

//--- apr_console.sv
module apr_console (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    key_ex,
	input  logic                    key_ex_nxt,
	input  logic                    key_dep,
	input  logic                    key_dep_nxt,
	input  logic                    key_mem_stop,
	input  logic                    key_mem_cont,
	input  logic                    sw_addr_stop,
	input  apr_pkg::addr_t          mas,
	input  apr_pkg::word_t          datasw,
	output apr_pkg::addr_t          ma,
	output apr_pkg::word_t          ar,
	output apr_pkg::word_t          mb,
	output logic                    mc_stop,
	output membus_pkg::membus_req_t membus_req,
	input  membus_pkg::membus_rsp_t membus_rsp
);

	membus_pkg::key_pulses_t pulses;
	logic addr_match;
	logic mb_clr;
	logic mb_fm_bus;
	logic cycle_done;

	console_keys u_keys (
		.clk         (clk),
		.rst         (rst),
		.key_ex      (key_ex),
		.key_ex_nxt  (key_ex_nxt),
		.key_dep     (key_dep),
		.key_dep_nxt (key_dep_nxt),
		.cycle_done  (cycle_done),
		.pulses      (pulses)
	);

	memory_address u_ma (
		.clk          (clk),
		.rst          (rst),
		.pulses       (pulses),
		.mas          (mas),
		.sw_addr_stop (sw_addr_stop),
		.ma           (ma),
		.addr_match   (addr_match)
	);

	// Read data goes straight from the bus into mb
	ar_mb_path u_armb (
		.clk       (clk),
		.rst       (rst),
		.pulses    (pulses),
		.datasw    (datasw),
		.mb_clr    (mb_clr),
		.mb_fm_bus (mb_fm_bus),
		.bus_word  (membus_rsp.mb_in),
		.ar        (ar),
		.mb        (mb)
	);

	membus_ctl u_mc (
		.clk          (clk),
		.rst          (rst),
		.pulses       (pulses),
		.ma           (ma),
		.addr_match   (addr_match),
		.mb           (mb),
		.key_mem_stop (key_mem_stop),
		.key_mem_cont (key_mem_cont),
		.rsp          (membus_rsp),
		.req          (membus_req),
		.mb_clr       (mb_clr),
		.mb_fm_bus    (mb_fm_bus),
		.mc_stop      (mc_stop),
		.cycle_done   (cycle_done)
	);

endmodule

//--- apr_console_assertions.sv
module apr_console_assertions (
	input logic                    clk,
	input logic                    rst,
	input membus_pkg::membus_req_t req
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_count;

	initial fail_count = 0;

	// A cycle is a read or a write, never both
	rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
		!(req.rd_rq && req.wr_rq))
	else begin
		fail_count++;
		$error("rd_rq and wr_rq high in the same cycle");
	end

	wr_rs_pulse: assert property (@(posedge clk) disable iff (rst)
		req.wr_rs |=> !req.wr_rs)
	else begin
		fail_count++;
		$error("wr_rs held for more than one cycle");
	end

	// Bus data only during the write restart
	mb_out_idle: assert property (@(posedge clk) disable iff (rst)
		!req.wr_rs |-> (req.mb_out == '0))
	else begin
		fail_count++;
		$error("mb_out not zero outside wr_rs");
	end

endmodule

bind membus_ctl apr_console_assertions u_bus_chk (.clk(clk), .rst(rst), .req(req));

//--- tb_apr_console.sv
module tb_apr_console;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int K_EX = 0;
	localparam int K_EX_NXT = 1;
	localparam int K_DEP = 2;
	localparam int K_DEP_NXT = 3;
	localparam int OP_CYCLES = 50;	// A timed out cycle is the longest
	localparam int NUM_OPS = 28;
	localparam int CYCLE_LIMIT = 20 * OP_CYCLES * NUM_OPS;

	logic clk = 1'b0;
	logic rst;
	logic [3:0] keys;
	logic key_mem_stop;
	logic key_mem_cont;
	logic sw_addr_stop;
	apr_pkg::addr_t mas;
	apr_pkg::word_t datasw;
	apr_pkg::addr_t ma;
	apr_pkg::word_t ar;
	apr_pkg::word_t mb;
	logic mc_stop;
	membus_pkg::membus_req_t membus_req;
	membus_pkg::membus_rsp_t membus_rsp;

	apr_pkg::word_t mem [64];	// Memory model
	apr_pkg::word_t ref_mem [64];
	apr_pkg::addr_t bus_addr;
	apr_pkg::addr_t exp_ma;
	apr_pkg::word_t exp_ar;
	apr_pkg::word_t exp_mb;
	integer seed = 32'h8b27;
	int force_delay = -1;
	int ack_wait = -1;	// -2 once the current request is acknowledged
	int error_count = 0;
	int done_count = 0;
	int rq_count = 0;
	int op_start = 0;
	int cycle_count = 0;
	logic was_active;
	logic rq_cyc_q;

	always #4 clk = ~clk;

	apr_console u_dut (
		.clk          (clk),
		.rst          (rst),
		.key_ex       (keys[K_EX]),
		.key_ex_nxt   (keys[K_EX_NXT]),
		.key_dep      (keys[K_DEP]),
		.key_dep_nxt  (keys[K_DEP_NXT]),
		.key_mem_stop (key_mem_stop),
		.key_mem_cont (key_mem_cont),
		.sw_addr_stop (sw_addr_stop),
		.mas          (mas),
		.datasw       (datasw),
		.ma           (ma),
		.ar           (ar),
		.mb           (mb),
		.mc_stop      (mc_stop),
		.membus_req   (membus_req),
		.membus_rsp   (membus_rsp)
	);

	assign bus_addr = {membus_req.sel[18:20], membus_req.ma};

	function automatic apr_pkg::word_t fill_word(input int i);
		return {apr_pkg::half_t'(i) ^ 18'o525252, apr_pkg::half_t'(i * 37 + 5)};
	endfunction

	// Stored word or zero where no memory answers
	function automatic apr_pkg::word_t ref_examine(input apr_pkg::addr_t addr);
		return (addr < 18'd64) ? ref_mem[addr[30:35]] : '0;
	endfunction

	function automatic void ref_deposit(input apr_pkg::addr_t addr,
			input apr_pkg::word_t data);
		if (addr < 18'd64)
			ref_mem[addr[30:35]] = data;
	endfunction

	function automatic apr_pkg::word_t model_word(input apr_pkg::addr_t addr);
		return (addr < 18'd64) ? mem[addr[30:35]] : '0;
	endfunction

	function automatic apr_pkg::word_t rand_word();
		return apr_pkg::word_t'({$random(seed), $random(seed)});
	endfunction

	function automatic apr_pkg::addr_t rand_addr(input int limit);
		return apr_pkg::addr_t'($unsigned($random(seed)) % limit);
	endfunction

	task automatic compare_word(input string what, input apr_pkg::word_t got,
			input apr_pkg::word_t want);
		assert (got === want) else begin
			$display("** Error at %0t: %s is %o, expected %o", $time, what, got, want);
			error_count++;
		end
	endtask

	task automatic press_key(input int key);
		@(posedge clk);
		keys <= 4'b0001 << key;
		@(posedge clk);
		keys <= '0;
	endtask

	// Expected state from the console rules, then the key press
	task automatic start_op(input int key, input apr_pkg::addr_t addr,
			input apr_pkg::word_t data);
		op_start = done_count;
		if (key == K_EX || key == K_DEP)
			exp_ma = addr;	// Clear, then OR from the switches
		else
			exp_ma = exp_ma + 18'd1;
		if (key == K_DEP || key == K_DEP_NXT) begin
			exp_ar = data;
			exp_mb = data;
			ref_deposit(exp_ma, data);
		end else begin
			exp_mb = ref_examine(exp_ma);
		end
		@(posedge clk);
		mas    <= addr;
		datasw <= data;
		keys   <= 4'b0001 << key;
		@(posedge clk);
		keys <= '0;
	endtask

	task automatic wait_done();
		while (done_count == op_start)
			@(posedge clk);
	endtask

	task automatic run_op(input int key, input apr_pkg::addr_t addr,
			input apr_pkg::word_t data);
		start_op(key, addr, data);
		wait_done();
	endtask

	// Memory answers below 64 after 0 to 5 cycles and never above
	always @(posedge clk) begin
		membus_rsp <= '0;
		if (rst || !membus_req.rq_cyc) begin
			ack_wait = -1;
		end else if (bus_addr < 18'd64 && ack_wait != -2) begin
			if (ack_wait == -1)
				ack_wait = (force_delay >= 0) ? force_delay :
					int'($unsigned($random(seed)) % 6);
			if (ack_wait == 0) begin
				membus_rsp.addr_ack <= 1'b1;
				membus_rsp.rd_rs    <= membus_req.rd_rq;	// Read data with the ack
				membus_rsp.mb_in    <= membus_req.rd_rq ? mem[bus_addr[30:35]] : '0;
				ack_wait = -2;
			end else begin
				ack_wait = ack_wait - 1;
			end
		end
		if (!rst && membus_req.wr_rs) begin
			compare_word("mb_out", membus_req.mb_out, exp_ar);
			if (bus_addr < 18'd64)
				mem[bus_addr[30:35]] = membus_req.mb_out;
		end
	end

	// Compare after rd_rq or wr_rq falls
	always @(posedge clk) begin
		if (rst) begin
			was_active <= 1'b0;
			rq_cyc_q   <= 1'b0;
		end else begin
			was_active <= membus_req.rd_rq | membus_req.wr_rq;
			rq_cyc_q   <= membus_req.rq_cyc;
			if (membus_req.rq_cyc && !rq_cyc_q)
				rq_count <= rq_count + 1;
			if (was_active && !(membus_req.rd_rq || membus_req.wr_rq)) begin
				compare_word("ma", apr_pkg::word_t'(ma), apr_pkg::word_t'(exp_ma));
				compare_word("ar", ar, exp_ar);
				compare_word("mb", mb, exp_mb);
				compare_word("memory word", model_word(exp_ma), ref_examine(exp_ma));
				done_count <= done_count + 1;
			end
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Run stopped: %0d value errors, %0d bus protocol errors",
				error_count, u_dut.u_mc.u_bus_chk.fail_count);
			$display("TB FAILED");
			$finish;
		end
	end

	initial begin
		apr_pkg::addr_t a;
		int rq_before;
		int proto_errs;
		rst = 1'b1;
		keys = '0;
		key_mem_stop = 1'b0;
		key_mem_cont = 1'b0;
		sw_addr_stop = 1'b0;
		mas = '0;
		datasw = '0;
		membus_rsp = '0;
		for (int i = 0; i < 64; i++) begin
			mem[i] = fill_word(i);
			ref_mem[i] = fill_word(i);
		end
		exp_ma = '0;
		exp_ar = '0;
		exp_mb = '0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;

		repeat (8) begin
			a = rand_addr(64);
			run_op(K_DEP, a, rand_word());
			run_op(K_EX, a, '0);
		end

		a = rand_addr(61);
		run_op(K_DEP, a, rand_word());
		run_op(K_DEP_NXT, a, rand_word());
		run_op(K_DEP_NXT, a, rand_word());
		run_op(K_EX, a, '0);
		run_op(K_EX_NXT, a, '0);
		run_op(K_EX_NXT, a, '0);

		// ma wraps from the top address to zero
		run_op(K_DEP, 18'o777777, rand_word());
		run_op(K_DEP_NXT, 18'o777777, rand_word());
		run_op(K_EX_NXT, 18'o777777, '0);

		run_op(K_EX, apr_pkg::addr_t'(64 + rand_addr(4096)), '0);	// Non-existent memory

		a = rand_addr(64);
		@(posedge clk);
		sw_addr_stop <= 1'b1;
		start_op(K_EX, a, '0);
		while (!mc_stop)
			@(posedge clk);
		repeat (12) @(posedge clk);
		assert (mc_stop && membus_req.rd_rq) else begin
			$display("** Error at %0t: address stop did not hold the read", $time);
			error_count++;
		end
		key_mem_cont <= 1'b1;
		@(posedge clk);
		key_mem_cont <= 1'b0;
		sw_addr_stop <= 1'b0;
		wait_done();
		assert (!mc_stop) else begin
			$display("** Error at %0t: mc_stop still set after continue", $time);
			error_count++;
		end

		// Second key while the ack is late
		a = rand_addr(64);
		force_delay = 5;
		rq_before = rq_count;
		start_op(K_EX, a, '0);
		while (!membus_req.rq_cyc)
			@(posedge clk);
		press_key(K_EX_NXT);
		wait_done();
		repeat (16) @(posedge clk);
		assert (rq_count == rq_before + 1 && ma == a && !membus_req.rd_rq) else begin
			$display("** Error at %0t: key press during a cycle was not ignored", $time);
			error_count++;
		end
		force_delay = -1;

		repeat (4) @(posedge clk);
		proto_errs = u_dut.u_mc.u_bus_chk.fail_count;
		$display("Run complete: %0d value errors, %0d bus protocol errors",
			error_count, proto_errs);
		if (error_count == 0 && proto_errs == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

//--- apr_console.f
apr_pkg.sv
membus_pkg.sv
console_keys.sv
memory_address.sv
ar_mb_path.sv
membus_ctl.sv
apr_console.sv
apr_console_assertions.sv
tb_apr_console.sv
